// File: vec_pkg.sv
`default_nettype none

package vec_pkg;

    // host bus geometry
    localparam int host_dw = 32;
    localparam int host_aw = 6;

    // operand banks, one element per word
    localparam logic [host_aw-1:0] addr_a_base = 6'h00;
    localparam logic [host_aw-1:0] addr_b_base = 6'h10;

    // bit 0 written as one starts a run, reads back as zero
    localparam logic [host_aw-1:0] addr_ctrl = 6'h20;

    localparam logic [host_aw-1:0] addr_status = 6'h21;

    // low word of the dot sum
    localparam logic [host_aw-1:0] addr_dot = 6'h22;

    // product buffer, one sign-extended product per word
    localparam logic [host_aw-1:0] addr_prod_base = 6'h30;

    // status word layout
    localparam int status_busy_bit = 0;
    localparam int status_done_bit = 1;

endpackage

`default_nettype wire

// File: vec_eng_if.sv
`default_nettype none

interface vec_eng_if #(
    parameter int VECTOR_SIZE = 5,
    parameter int CELL_WIDTH  = 8,
    parameter int TILING      = 1
) ();

    localparam int PW    = 2 * CELL_WIDTH;
    localparam int SUM_W = PW + $clog2(VECTOR_SIZE);
    localparam int IDX_W = (VECTOR_SIZE > 1) ? $clog2(VECTOR_SIZE) : 1;

    logic                          start;
    logic [VECTOR_SIZE*CELL_WIDTH-1:0] a_vec;
    logic [VECTOR_SIZE*CELL_WIDTH-1:0] b_vec;

    // one tile of TILING products, element index of its first lane
    logic                          tile_valid;
    logic [IDX_W-1:0]              tile_index;
    logic [TILING*PW-1:0]          tile_prod;

    logic                          done;
    logic signed [SUM_W-1:0]       dot_sum;

    modport regs (
        output start, a_vec, b_vec,
        input  tile_valid, tile_index, tile_prod, done, dot_sum
    );

    modport mul (
        input  start, a_vec, b_vec,
        output tile_valid, tile_index, tile_prod
    );

    modport acc (
        input  start, tile_valid, tile_prod,
        output done, dot_sum
    );

endinterface

`default_nettype wire

// File: vec_regs.sv
`default_nettype none

module vec_regs #(
    parameter int VECTOR_SIZE = 5,
    parameter int CELL_WIDTH  = 8,
    parameter int TILING      = 1
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req,
    input  logic                        we,
    input  logic [vec_pkg::host_aw-1:0] addr,
    input  logic [vec_pkg::host_dw-1:0] wdata,
    output logic                        ack,
    output logic [vec_pkg::host_dw-1:0] rdata,
    vec_eng_if.regs                     eng
);

    localparam int DW     = vec_pkg::host_dw;
    localparam int AW     = vec_pkg::host_aw;
    localparam int PW     = 2 * CELL_WIDTH;
    localparam int SUM_W  = PW + $clog2(VECTOR_SIZE);
    localparam int WIDE_W = SUM_W + DW;
    localparam int IDX_W  = (VECTOR_SIZE > 1) ? $clog2(VECTOR_SIZE) : 1;

    logic signed [CELL_WIDTH-1:0] a_mem [VECTOR_SIZE];
    logic signed [CELL_WIDTH-1:0] b_mem [VECTOR_SIZE];
    logic signed [PW-1:0]         prod_mem [VECTOR_SIZE];
    logic signed [SUM_W-1:0]      dot_q;
    logic signed [WIDE_W-1:0]     dot_wide;
    logic                         busy;
    logic                         done;

    logic [AW-1:0] a_off;
    logic [AW-1:0] b_off;
    logic [AW-1:0] p_off;
    logic          a_hit;
    logic          b_hit;
    logic          p_hit;
    logic          access;
    logic          start_req;
    logic [DW-1:0] rd_next;

    // a new transfer is seen once, while ack is still low
    assign access = req && !ack;

    // offsets wrap below the base, so one compare covers the range
    assign a_off = addr - vec_pkg::addr_a_base;
    assign b_off = addr - vec_pkg::addr_b_base;
    assign p_off = addr - vec_pkg::addr_prod_base;
    assign a_hit = a_off < VECTOR_SIZE;
    assign b_hit = b_off < VECTOR_SIZE;
    assign p_hit = p_off < VECTOR_SIZE;

    assign start_req = access && we && (addr == vec_pkg::addr_ctrl) && wdata[0] && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else if (req && !ack) begin
            ack <= 1'b1;
        end else if (!req && ack) begin
            ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (access && !we) begin
            rdata <= rd_next;
        end
    end

    // run control; a start while busy is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            eng.start <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            dot_q     <= '0;
        end else begin
            eng.start <= start_req;
            if (start_req) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (eng.done) begin
                busy  <= 1'b0;
                done  <= 1'b1;
                dot_q <= eng.dot_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < VECTOR_SIZE; i++) begin
                a_mem[i]    <= '0;
                b_mem[i]    <= '0;
                prod_mem[i] <= '0;
            end
        end else begin
            if (access && we && a_hit) begin
                a_mem[a_off[IDX_W-1:0]] <= wdata[CELL_WIDTH-1:0];
            end
            if (access && we && b_hit) begin
                b_mem[b_off[IDX_W-1:0]] <= wdata[CELL_WIDTH-1:0];
            end
            // a tile lands at consecutive slots from its first lane
            if (eng.tile_valid) begin
                for (int j = 0; j < TILING; j++) begin
                    prod_mem[eng.tile_index + IDX_W'(j)] <= eng.tile_prod[j*PW +: PW];
                end
            end
        end
    end

    assign dot_wide = WIDE_W'(dot_q);

    always_comb begin
        rd_next = '0;
        if (a_hit) begin
            rd_next = DW'(a_mem[a_off[IDX_W-1:0]]);
        end else if (b_hit) begin
            rd_next = DW'(b_mem[b_off[IDX_W-1:0]]);
        end else if (p_hit) begin
            rd_next = DW'(prod_mem[p_off[IDX_W-1:0]]);
        end else if (addr == vec_pkg::addr_status) begin
            rd_next[vec_pkg::status_busy_bit] = busy;
            rd_next[vec_pkg::status_done_bit] = done;
        end else if (addr == vec_pkg::addr_dot) begin
            rd_next = dot_wide[DW-1:0];
        end
    end

    always_comb begin
        for (int i = 0; i < VECTOR_SIZE; i++) begin
            eng.a_vec[i*CELL_WIDTH +: CELL_WIDTH] = a_mem[i];
            eng.b_vec[i*CELL_WIDTH +: CELL_WIDTH] = b_mem[i];
        end
    end

endmodule

`default_nettype wire

// File: vec_mul_lanes.sv
`default_nettype none

module vec_mul_lanes #(
    parameter int VECTOR_SIZE = 5,
    parameter int CELL_WIDTH  = 8,
    parameter int TILING      = 1
) (
    input  logic   clk,
    input  logic   rst,
    vec_eng_if.mul eng
);

    localparam int PW    = 2 * CELL_WIDTH;
    localparam int IDX_W = (VECTOR_SIZE > 1) ? $clog2(VECTOR_SIZE) : 1;
    // first element of the final tile
    localparam int LAST  = VECTOR_SIZE - TILING;

    localparam logic IDLE = 1'b0;
    localparam logic RUN  = 1'b1;

    logic             state;
    logic [IDX_W-1:0] counter;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            counter <= '0;
        end else begin
            case (state)
                IDLE: begin
                    counter <= '0;
                    if (eng.start) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (counter == IDX_W'(LAST)) begin
                        state   <= IDLE;
                        counter <= '0;
                    end else begin
                        counter <= counter + IDX_W'(TILING);
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // one signed multiplier per lane
    for (genvar j = 0; j < TILING; j++) begin : g_lane
        logic signed [CELL_WIDTH-1:0] a_el;
        logic signed [CELL_WIDTH-1:0] b_el;

        assign a_el = eng.a_vec[(int'(counter) + j) * CELL_WIDTH +: CELL_WIDTH];
        assign b_el = eng.b_vec[(int'(counter) + j) * CELL_WIDTH +: CELL_WIDTH];
        assign eng.tile_prod[j*PW +: PW] = a_el * b_el;
    end

    // a tile goes out every cycle spent in RUN
    assign eng.tile_valid = (state == RUN);
    assign eng.tile_index = counter;

endmodule

`default_nettype wire

// File: vec_accum.sv
`default_nettype none

module vec_accum #(
    parameter int VECTOR_SIZE = 5,
    parameter int CELL_WIDTH  = 8,
    parameter int TILING      = 1
) (
    input  logic   clk,
    input  logic   rst,
    vec_eng_if.acc eng
);

    localparam int PW     = 2 * CELL_WIDTH;
    localparam int SUM_W  = PW + $clog2(VECTOR_SIZE);
    localparam int NTILES = VECTOR_SIZE / TILING;
    localparam int CNT_W  = $clog2(NTILES + 1);

    logic [CNT_W-1:0]        tile_cnt;
    logic signed [SUM_W-1:0] sum_q;
    logic signed [SUM_W-1:0] tile_sum;

    // adder chain across the lanes of one tile
    always_comb begin
        tile_sum = '0;
        for (int j = 0; j < TILING; j++) begin
            tile_sum = tile_sum + SUM_W'($signed(eng.tile_prod[j*PW +: PW]));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_q    <= '0;
            tile_cnt <= '0;
            eng.done <= 1'b0;
        end else begin
            eng.done <= 1'b0;
            if (eng.start) begin
                sum_q    <= '0;
                tile_cnt <= '0;
            end else if (eng.tile_valid) begin
                sum_q <= sum_q + tile_sum;
                // done follows the last tile by one cycle
                if (tile_cnt == CNT_W'(NTILES - 1)) begin
                    tile_cnt <= '0;
                    eng.done <= 1'b1;
                end else begin
                    tile_cnt <= tile_cnt + 1'b1;
                end
            end
        end
    end

    assign eng.dot_sum = sum_q;

endmodule

`default_nettype wire

// File: vec_dot_top.sv
`default_nettype none

module vec_dot_top #(
    // VECTOR_SIZE at most 16 and a multiple of TILING
    parameter int VECTOR_SIZE = 5,
    // at most 16 so a product fits one host word
    parameter int CELL_WIDTH  = 8,
    parameter int TILING      = 1
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req,
    input  logic                        we,
    input  logic [vec_pkg::host_aw-1:0] addr,
    input  logic [vec_pkg::host_dw-1:0] wdata,
    output logic                        ack,
    output logic [vec_pkg::host_dw-1:0] rdata
);

    vec_eng_if #(
        .VECTOR_SIZE (VECTOR_SIZE),
        .CELL_WIDTH  (CELL_WIDTH),
        .TILING      (TILING)
    ) eng ();

    // host side, operand and result storage
    vec_regs #(
        .VECTOR_SIZE (VECTOR_SIZE),
        .CELL_WIDTH  (CELL_WIDTH),
        .TILING      (TILING)
    ) regs0 (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata),
        .eng   (eng.regs)
    );

    vec_mul_lanes #(
        .VECTOR_SIZE (VECTOR_SIZE),
        .CELL_WIDTH  (CELL_WIDTH),
        .TILING      (TILING)
    ) mul0 (
        .clk (clk),
        .rst (rst),
        .eng (eng.mul)
    );

    vec_accum #(
        .VECTOR_SIZE (VECTOR_SIZE),
        .CELL_WIDTH  (CELL_WIDTH),
        .TILING      (TILING)
    ) acc0 (
        .clk (clk),
        .rst (rst),
        .eng (eng.acc)
    );

endmodule

`default_nettype wire

// File: tb_vec_tasks.svh
`ifndef TB_VEC_TASKS_SVH
`define TB_VEC_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
        errors++;
        $display("error at %0t: %s got %h expected %h", $time, name, got, expected);
    end
endtask

// four-phase write, returns once ack has dropped
task automatic host_write(input logic [5:0] a, input logic [31:0] d);
    @(negedge clk);
    addr  = a;
    wdata = d;
    we    = 1'b1;
    req   = 1'b1;
    @(negedge clk);
    while (ack !== 1'b1) @(negedge clk);
    req = 1'b0;
    we  = 1'b0;
    while (ack !== 1'b0) @(negedge clk);
endtask

task automatic host_read(input logic [5:0] a, output logic [31:0] d);
    @(negedge clk);
    addr = a;
    we   = 1'b0;
    req  = 1'b1;
    @(negedge clk);
    while (ack !== 1'b1) @(negedge clk);
    d   = rdata;
    req = 1'b0;
    while (ack !== 1'b0) @(negedge clk);
endtask

task automatic read_check(input string name, input logic [5:0] a, input logic [31:0] expected);
    logic [31:0] d;
    host_read(a, d);
    check_value(name, d, expected);
endtask

task automatic load_operands();
    for (int i = 0; i < VS; i++) begin
        host_write(vec_pkg::addr_a_base + 6'(i), a_exp[i]);
        host_write(vec_pkg::addr_b_base + 6'(i), b_exp[i]);
    end
endtask

// start a run; it lasts longer than one status read
task automatic start_run();
    host_write(vec_pkg::addr_ctrl, 32'h1);
    read_check("status after start", vec_pkg::addr_status, status_word(1'b1, 1'b0));
endtask

task automatic wait_done();
    logic [31:0] s;
    int          polls;
    polls = 0;
    s     = '0;
    while (!s[vec_pkg::status_done_bit] && polls < POLL_LIMIT) begin
        host_read(vec_pkg::addr_status, s);
        polls++;
    end
    if (!s[vec_pkg::status_done_bit]) begin
        errors++;
        $display("done did not rise within %0d status reads", POLL_LIMIT);
    end
endtask

task automatic check_results();
    int sum;
    sum = 0;
    for (int i = 0; i < VS; i++) begin
        read_check($sformatf("prod[%0d]", i), vec_pkg::addr_prod_base + 6'(i),
                   a_exp[i] * b_exp[i]);
        sum += a_exp[i] * b_exp[i];
    end
    read_check("dot", vec_pkg::addr_dot, sum);
    read_check("status when done", vec_pkg::addr_status, status_word(1'b0, 1'b1));
endtask

task automatic fill_random();
    for (int i = 0; i < VS; i++) begin
        a_exp[i] = sext_cell(rand_bits(CW));
        b_exp[i] = sext_cell(rand_bits(CW));
    end
endtask

task automatic test_reset_values();
    int errs;
    errs = errors;
    read_check("status", vec_pkg::addr_status, '0);
    read_check("dot", vec_pkg::addr_dot, '0);
    read_check("ctrl", vec_pkg::addr_ctrl, '0);
    for (int i = 0; i < VS; i++) begin
        read_check($sformatf("prod[%0d]", i), vec_pkg::addr_prod_base + 6'(i), '0);
    end
    read_check("unmapped 0x28", 6'h28, '0);
    read_check("unmapped past prod", vec_pkg::addr_prod_base + 6'(VS), '0);
    report_test("reset_values", errs);
endtask

task automatic test_operand_readback();
    int          errs;
    logic [31:0] da;
    logic [31:0] db;
    errs = errors;
    for (int i = 0; i < VS; i++) begin
        // upper bits carry junk that the cell drops
        da = 32'ha5a5_a500 + 32'(i * 53 + 7);
        db = 32'h5a5a_5a80 + 32'(i * 29);
        host_write(vec_pkg::addr_a_base + 6'(i), da);
        host_write(vec_pkg::addr_b_base + 6'(i), db);
        read_check($sformatf("a[%0d]", i), vec_pkg::addr_a_base + 6'(i), sext_cell(da));
        read_check($sformatf("b[%0d]", i), vec_pkg::addr_b_base + 6'(i), sext_cell(db));
    end
    report_test("operand_readback", errs);
endtask

task automatic test_fixed_run();
    int errs;
    int min_cell;
    int max_cell;
    errs     = errors;
    min_cell = -(1 << (CW - 1));
    max_cell = (1 << (CW - 1)) - 1;
    for (int i = 0; i < VS; i++) begin
        a_exp[i] = (i % 2 == 0) ? min_cell : max_cell;
        b_exp[i] = (i % 3 == 0) ? min_cell : ((i % 3 == 1) ? max_cell : -1);
    end
    load_operands();
    start_run();
    wait_done();
    check_results();
    report_test("fixed_run", errs);
endtask

task automatic test_random_runs();
    int errs;
    errs = errors;
    for (int r = 0; r < 3; r++) begin
        fill_random();
        load_operands();
        start_run();
        wait_done();
        check_results();
    end
    report_test("random_runs", errs);
endtask

task automatic test_start_while_busy();
    int errs;
    errs = errors;
    fill_random();
    load_operands();
    host_write(vec_pkg::addr_ctrl, 32'h1);
    // second start lands well inside the run
    host_write(vec_pkg::addr_ctrl, 32'h1);
    wait_done();
    // no second run may follow, so done stays set and busy stays low
    for (int k = 0; k < 8; k++) begin
        read_check("status after done", vec_pkg::addr_status, status_word(1'b0, 1'b1));
    end
    check_results();
    report_test("start_while_busy", errs);
endtask

task automatic test_restart();
    int errs;
    errs = errors;
    fill_random();
    load_operands();
    start_run();
    wait_done();
    check_results();
    for (int i = 0; i < VS; i++) begin
        a_exp[i] = i + 2;
        b_exp[i] = -3 * i - 1;
    end
    load_operands();
    start_run();
    wait_done();
    check_results();
    report_test("restart", errs);
endtask

`endif

// File: tb_vec_dot.sv
`default_nettype none

module tb_vec_dot;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int VS = 5;
    localparam int CW = 8;
    localparam int TL = 1;

    localparam int NUM_TESTS  = 6;
    localparam int TEST_BOUND = 2000;
    localparam int POLL_LIMIT = 200;

    logic                        clk;
    logic                        rst;
    logic                        req;
    logic                        we;
    logic [vec_pkg::host_aw-1:0] addr;
    logic [vec_pkg::host_dw-1:0] wdata;
    logic                        ack;
    logic [vec_pkg::host_dw-1:0] rdata;

    // operands as the DUT should hold them, sign-extended
    int a_exp [VS];
    int b_exp [VS];

    int          errors;
    int          checks;
    int          tests_run;
    logic [31:0] lfsr;

    vec_dot_top #(
        .VECTOR_SIZE (VS),
        .CELL_WIDTH  (CW),
        .TILING      (TL)
    ) dut0 (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata)
    );

    `include "tb_vec_tasks.svh"

    // taps 32, 22, 2, 1
    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_lfsr_bit()};
        end
        return r;
    endfunction

    // keep the low CW bits of a word, sign-extended
    function automatic int sext_cell(input logic [31:0] v);
        logic signed [CW-1:0] c;
        c = v[CW-1:0];
        return int'(c);
    endfunction

    function automatic logic [31:0] status_word(input logic busy, input logic done);
        logic [31:0] w;
        w = '0;
        w[vec_pkg::status_busy_bit] = busy;
        w[vec_pkg::status_done_bit] = done;
        return w;
    endfunction

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-22s ok", name);
        end else begin
            $display("test %-22s FAILED with %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // bound on the whole run, from the number of tests
    initial begin
        repeat (NUM_TESTS * TEST_BOUND) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish",
                 NUM_TESTS * TEST_BOUND);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        req       = 1'b0;
        we        = 1'b0;
        addr      = '0;
        wdata     = '0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        lfsr      = 32'hd079;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_values();
        test_operand_readback();
        test_fixed_run();
        test_random_runs();
        test_start_while_busy();
        test_restart();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
vec_pkg.sv
vec_eng_if.sv
vec_regs.sv
vec_mul_lanes.sv
vec_accum.sv
vec_dot_top.sv
tb_vec_dot.sv

// File: run.sh
#!/bin/sh
# compile and run the vec_dot testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --top-module tb_vec_dot -f all.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_vec_dot > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation did not pass, see sim.log"
exit 1
